/* hdl/apb_regfile_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps
/*
	APB slave giving the bus access to the physical register file
	zero wait states, word addressed, with pslverr for addresses past the file
	writes go out as a one-cycle strobe, reads return data in the access cycle
*/

module apb_regfile_ctrl
	import regsel_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [APB_ADDR_W-1:0] paddr_i,
	input  logic [DATA_W-1:0]     pwdata_i,
	output logic [DATA_W-1:0]     prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	output logic                  wr_en_o,
	output logic [PREG_W-1:0]     wr_reg_o,
	output logic [DATA_W-1:0]     wr_data_o,
	output logic [PREG_W-1:0]     apb_rd_reg_o,
	input  logic [DATA_W-1:0]     apb_rd_data_i
);

	// phase of the current cycle as decoded straight from psel and penable
	apb_state_t cur_phase;
	// phase of the previous cycle
	apb_state_t prev_phase;

	// word address with the byte lane bits dropped
	logic [APB_ADDR_W-3:0] word_addr;
	logic                  in_range;
	logic                  access;
	logic                  xfer_ok;

	// ==============================
	// phase tracking
	// ==============================
	always_comb begin
		if (!psel_i) begin
			cur_phase = APB_IDLE;
		end else if (!penable_i) begin
			cur_phase = APB_SETUP;
		end else begin
			cur_phase = APB_ACCESS;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prev_phase <= APB_IDLE;
		end else begin
			prev_phase <= cur_phase;
		end
	end

	// an access only counts when a setup cycle came right before it,
	// which keeps a held penable from producing a second write strobe
	assign access  = (cur_phase == APB_ACCESS);
	assign xfer_ok = access && (prev_phase == APB_SETUP);

	// ==============================
	// address decode
	// ==============================
	assign word_addr = paddr_i[APB_ADDR_W-1:2];
	assign in_range  = (word_addr < (APB_ADDR_W-2)'(NUM_PREG));

	// there are no wait states, so every access cycle completes
	assign pready_o  = access;
	assign pslverr_o = access && !in_range;

	// the write strobe to the register file is dropped for bad addresses
	assign wr_en_o   = xfer_ok && pwrite_i && in_range;
	assign wr_reg_o  = word_addr[PREG_W-1:0];
	assign wr_data_o = pwdata_i;

	// readback data is zero outside a good read access
	assign apb_rd_reg_o = word_addr[PREG_W-1:0];
	assign prdata_o     = (xfer_ok && !pwrite_i && in_range) ? apb_rd_data_i : '0;

endmodule

`default_nettype wire

/* hdl/phys_regfile.sv */
`default_nettype none
`timescale 1ns/10ps
/*
	physical register file
	one synchronous write port fed by the APB slave, NUM_RDPORT combinational
	read ports addressed by the selector and one more read port for APB readback
*/

module phys_regfile
	import regsel_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              wr_en_i,
	input  logic [PREG_W-1:0]                 wr_reg_i,
	input  logic [DATA_W-1:0]                 wr_data_i,
	input  logic [NUM_RDPORT-1:0][PREG_W-1:0] rd_reg_i,
	output logic [NUM_RDPORT-1:0][DATA_W-1:0] rd_data_o,
	input  logic [PREG_W-1:0]                 apb_rd_reg_i,
	output logic [DATA_W-1:0]                 apb_rd_data_o
);

	// NUM_PREG words of storage
	logic [DATA_W-1:0] regs [NUM_PREG];

	// ==============================
	// write port
	// ==============================
	// synchronous write with every register cleared by reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_PREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i) begin
			regs[wr_reg_i] <= wr_data_i;
		end
	end

	// ==============================
	// read ports
	// ==============================
	// reads are asynchronous, so the data follows the selector's registered
	// register numbers within the same cycle
	always_comb begin
		for (int p = 0; p < NUM_RDPORT; p++) begin
			rd_data_o[p] = regs[rd_reg_i[p]];
		end
	end

	// readback port for the APB slave
	assign apb_rd_data_o = regs[apb_rd_reg_i];

endmodule

`default_nettype wire

/* hdl/read_data_route.sv */
`default_nettype none
`timescale 1ns/10ps
/*
	read data router
	turns the per-port view of the register file back into a per-requester
	view, using the source index and used bit the selector stored per port
	purely combinational, sits between the register file and req_data_o
*/

module read_data_route
	import regsel_pkg::*;
(
	input  logic [NUM_RDPORT-1:0][REQ_IDX_W-1:0] port_src_i,
	input  logic [NUM_RDPORT-1:0]                port_used_i,
	input  logic [NUM_RDPORT-1:0][DATA_W-1:0]    port_data_i,
	output logic [NUM_REQ-1:0][DATA_W-1:0]       req_data_o
);

	// match[r][p] is set when port p is serving requester r
	logic [NUM_REQ-1:0][NUM_RDPORT-1:0] match;

	// ==============================
	// port to requester match
	// ==============================
	always_comb begin
		for (int r = 0; r < NUM_REQ; r++) begin
			for (int p = 0; p < NUM_RDPORT; p++) begin
				// an idle port never matches, whatever its stale source says
				match[r][p] = port_used_i[p] && (port_src_i[p] == REQ_IDX_W'(r));
			end
		end
	end

	// ==============================
	// data select
	// ==============================
	// the selector gives each requester at most one port, so the match row
	// is one-hot or zero and an and-or mux is enough
	// no match leaves the word at 0, which is what an unserved requester sees
	always_comb begin
		req_data_o = '0;
		for (int r = 0; r < NUM_REQ; r++) begin
			for (int p = 0; p < NUM_RDPORT; p++) begin
				req_data_o[r] = req_data_o[r] | ({DATA_W{match[r][p]}} & port_data_i[p]);
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/read_port_select.sv */
`default_nettype none
`timescale 1ns/10ps
/*
	rotating read-port selector
	the first FIXED_PORTS requesters own ports 0 .. FIXED_PORTS-1 outright,
	the rest compete for the remaining ports starting at a pointer that
	steps every clock, so outputs are registered one cycle after sampling
*/

module read_port_select
	import regsel_pkg::*;
(
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic [NUM_REQ-1:0][PREG_W-1:0]       req_reg_i,
	input  logic [NUM_REQ-1:0]                   req_valid_i,
	output logic [NUM_REQ-1:0]                   req_ack_o,
	output logic [NUM_RDPORT-1:0][PREG_W-1:0]    port_reg_o,
	output logic [NUM_RDPORT-1:0][REQ_IDX_W-1:0] port_src_o,
	output logic [NUM_RDPORT-1:0]                port_used_o
);

	// rotation pointer counting modulo DYN_REQ
	logic [REQ_IDX_W-1:0] rot_ptr;

	// next values of the registered outputs
	logic [NUM_REQ-1:0]                   ack_nxt;
	logic [NUM_RDPORT-1:0][PREG_W-1:0]    reg_nxt;
	logic [NUM_RDPORT-1:0][REQ_IDX_W-1:0] src_nxt;
	logic [NUM_RDPORT-1:0]                used_nxt;

	// next free port and the rotated dynamic index inside the scan
	int slot;
	int rot;

	// ==============================
	// rotation pointer
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			rot_ptr <= '0;
		end else if (rot_ptr == REQ_IDX_W'(DYN_REQ - 1)) begin
			rot_ptr <= '0;
		end else begin
			rot_ptr <= rot_ptr + 1'b1;
		end
	end

	// ==============================
	// port allocation
	// ==============================
	always_comb begin
		ack_nxt  = '0;
		reg_nxt  = '0;
		src_nxt  = '0;
		used_nxt = '0;
		slot     = FIXED_PORTS;
		rot      = 0;
		// fixed requesters are granted whether or not they are valid
		for (int h = 0; h < FIXED_PORTS; h++) begin
			ack_nxt[h]  = 1'b1;
			reg_nxt[h]  = req_reg_i[h];
			src_nxt[h]  = REQ_IDX_W'(h);
			used_nxt[h] = 1'b1;
		end
		// walk the dynamic requesters from the pointer and hand out ports in order
		for (int j = 0; j < DYN_REQ; j++) begin
			// j and rot_ptr are both below DYN_REQ, so one subtract does the modulo
			rot = j + int'(rot_ptr);
			if (rot >= DYN_REQ) begin
				rot = rot - DYN_REQ;
			end
			if (slot < NUM_RDPORT && req_valid_i[FIXED_PORTS + rot]) begin
				ack_nxt[FIXED_PORTS + rot] = 1'b1;
				reg_nxt[slot]              = req_reg_i[FIXED_PORTS + rot];
				src_nxt[slot]              = REQ_IDX_W'(FIXED_PORTS + rot);
				used_nxt[slot]             = 1'b1;
				slot                       = slot + 1;
			end
		end
	end

	// registered acks and port usage
	always_ff @(posedge clk) begin
		if (rst) begin
			req_ack_o   <= '0;
			port_used_o <= '0;
		end else begin
			req_ack_o   <= ack_nxt;
			port_used_o <= used_nxt;
		end
	end

	// registered register numbers and requester sources for each port
	always_ff @(posedge clk) begin
		port_reg_o <= reg_nxt;
		port_src_o <= src_nxt;
	end

endmodule

`default_nettype wire

/* hdl/regread_top.sv */
`default_nettype none
`timescale 1ns/10ps
/*
	top level of the register-read subsystem
	selector, register file, data router and APB slave wired together
*/

module regread_top
	import regsel_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic [NUM_REQ-1:0][PREG_W-1:0] req_reg_i,
	input  logic [NUM_REQ-1:0]             req_valid_i,
	output logic [NUM_REQ-1:0]             req_ack_o,
	output logic [NUM_REQ-1:0][DATA_W-1:0] req_data_o,
	input  logic                           psel_i,
	input  logic                           penable_i,
	input  logic                           pwrite_i,
	input  logic [APB_ADDR_W-1:0]          paddr_i,
	input  logic [DATA_W-1:0]              pwdata_i,
	output logic [DATA_W-1:0]              prdata_o,
	output logic                           pready_o,
	output logic                           pslverr_o
);

	// selector to register file and router
	logic [NUM_RDPORT-1:0][PREG_W-1:0]    port_reg;
	logic [NUM_RDPORT-1:0][REQ_IDX_W-1:0] port_src;
	logic [NUM_RDPORT-1:0]                port_used;
	logic [NUM_RDPORT-1:0][DATA_W-1:0]    port_data;

	// APB slave to register file
	logic              wr_en;
	logic [PREG_W-1:0] wr_reg;
	logic [DATA_W-1:0] wr_data;
	logic [PREG_W-1:0] apb_rd_reg;
	logic [DATA_W-1:0] apb_rd_data;

	read_port_select u_sel (.clk(clk), .rst(rst), .req_reg_i(req_reg_i),
		.req_valid_i(req_valid_i), .req_ack_o(req_ack_o), .port_reg_o(port_reg),
		.port_src_o(port_src), .port_used_o(port_used));

	phys_regfile u_rf (.clk(clk), .rst(rst), .wr_en_i(wr_en), .wr_reg_i(wr_reg),
		.wr_data_i(wr_data), .rd_reg_i(port_reg), .rd_data_o(port_data),
		.apb_rd_reg_i(apb_rd_reg), .apb_rd_data_o(apb_rd_data));

	read_data_route u_route (.port_src_i(port_src), .port_used_i(port_used),
		.port_data_i(port_data), .req_data_o(req_data_o));

	apb_regfile_ctrl u_apb (.clk(clk), .rst(rst), .psel_i(psel_i), .penable_i(penable_i),
		.pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pready_o(pready_o), .pslverr_o(pslverr_o), .wr_en_o(wr_en), .wr_reg_o(wr_reg),
		.wr_data_o(wr_data), .apb_rd_reg_o(apb_rd_reg), .apb_rd_data_i(apb_rd_data));

endmodule

`default_nettype wire

/* hdl/regsel_pkg.sv */
`default_nettype none
/*
	shared sizes and types for the register-read arbitration subsystem
	the RTL blocks and the testbench take them in with a wildcard import
*/

package regsel_pkg;

	// ==============================
	// requester and port counts
	// ==============================
	localparam int NUM_REQ     = 8;
	localparam int NUM_RDPORT  = 4;
	localparam int FIXED_PORTS = 2;
	// requesters past the fixed ones share the leftover ports
	localparam int DYN_REQ     = NUM_REQ - FIXED_PORTS;

	// register file geometry
	localparam int NUM_PREG   = 32;
	localparam int PREG_W     = $clog2(NUM_PREG);
	localparam int DATA_W     = 32;
	localparam int REQ_IDX_W  = $clog2(NUM_REQ);
	localparam int APB_ADDR_W = 8;

	// bus phase as seen by the APB slave
	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_state_t;

endpackage

`default_nettype wire

/* project.f */
hdl/regsel_pkg.sv
hdl/read_port_select.sv
hdl/phys_regfile.sv
hdl/read_data_route.sv
hdl/apb_regfile_ctrl.sv
hdl/regread_top.sv
verif/tb_regread.sv

/* run_sim.sh */
#!/bin/sh
# builds the register-read testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_regread -o sim_regread
out=$(./obj_dir/sim_regread)
echo "$out"
if echo "$out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1

/* verif/tb_regread.sv */
`default_nettype none
`timescale 1ns/10ps
/*
	testbench for the register-read subsystem
	loads the register file over APB and keeps a shadow copy of it, then runs
	the requester side with directed and random patterns
	immediate assertions check acks, read data and fairness in every cycle
*/

module tb_regread
	import regsel_pkg::*;
();

	logic                           clk;
	logic                           rst;
	logic [NUM_REQ-1:0][PREG_W-1:0] req_reg;
	logic [NUM_REQ-1:0]             req_valid;
	logic [NUM_REQ-1:0]             req_ack;
	logic [NUM_REQ-1:0][DATA_W-1:0] req_data;
	logic                           psel;
	logic                           penable;
	logic                           pwrite;
	logic [APB_ADDR_W-1:0]          paddr;
	logic [DATA_W-1:0]              pwdata;
	logic [DATA_W-1:0]              prdata;
	logic                           pready;
	logic                           pslverr;

	// shadow of the register file that is updated in the access cycle of a good write
	logic [DATA_W-1:0] shadow [NUM_PREG];

	// requests as the selector samples them at the coming rising edge
	logic [NUM_REQ-1:0][PREG_W-1:0] prev_reg;
	logic [NUM_REQ-1:0]             prev_valid;
	logic                           prev_live;
	// acks gathered since the last clear for the fairness test
	logic [NUM_REQ-1:0]             acked_since;

	integer     seed;
	int         errors;
	int         err_base;
	int         tests_run;
	int         tests_failed;

	regread_top UUT (.clk(clk), .rst(rst), .req_reg_i(req_reg), .req_valid_i(req_valid),
		.req_ack_o(req_ack), .req_data_o(req_data), .psel_i(psel), .penable_i(penable),
		.pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
		.pready_o(pready), .pslverr_o(pslverr));

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// hard stop in case the stimulus never reaches its end
	initial begin
		for (int c = 0; c < 5000; c++) begin
			@(posedge clk);
		end
		$display("simulation ran past its cycle limit without finishing");
		$display("Test FAILED");
		$finish;
	end

	// ==============================
	// helpers
	// ==============================
	task automatic report_fail(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (errors == err_base) begin
			$display("test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_base);
		end
		err_base = errors;
	endtask

	task automatic drive_phase(input apb_state_t ph);
		psel    = (ph != APB_IDLE);
		penable = (ph == APB_ACCESS);
	endtask

	task automatic draw_requests();
		for (int i = 0; i < NUM_REQ; i++) begin
			req_reg[i] = PREG_W'($random(seed));
		end
		req_valid = NUM_REQ'($random(seed));
	endtask

	// the requests held now are sampled at the rising edge and the answer
	// is checked at the following falling edge, where it is stable
	task automatic step();
		int dyn_acks;
		int dyn_valid;
		prev_reg   = req_reg;
		prev_valid = req_valid;
		prev_live  = !rst;
		@(negedge clk);
		if (prev_live) begin
			dyn_acks  = 0;
			dyn_valid = 0;
			for (int h = 0; h < FIXED_PORTS; h++) begin
				assert (req_ack[h]) else
					report_fail($sformatf("fixed requester %0d not acked", h));
				assert (req_data[h] == shadow[prev_reg[h]]) else
					report_fail($sformatf("requester %0d got 0x%08h, expected 0x%08h",
						h, req_data[h], shadow[prev_reg[h]]));
			end
			for (int r = FIXED_PORTS; r < NUM_REQ; r++) begin
				if (prev_valid[r]) begin
					dyn_valid++;
				end
				if (req_ack[r]) begin
					dyn_acks++;
					assert (prev_valid[r]) else
						report_fail($sformatf("requester %0d acked without asking", r));
					assert (req_data[r] == shadow[prev_reg[r]]) else
						report_fail($sformatf("requester %0d got 0x%08h, expected 0x%08h",
							r, req_data[r], shadow[prev_reg[r]]));
				end else begin
					// an unserved requester sees zero data
					assert (req_data[r] == '0) else
						report_fail($sformatf("unserved requester %0d has data", r));
				end
			end
			assert (dyn_acks <= NUM_RDPORT - FIXED_PORTS) else
				report_fail($sformatf("%0d dynamic acks exceed the free ports", dyn_acks));
			assert (dyn_acks <= dyn_valid) else
				report_fail($sformatf("%0d dynamic acks for %0d requests", dyn_acks, dyn_valid));
			acked_since = acked_since | req_ack;
		end
	endtask

	// one APB transfer of a setup and an access cycle, with the access sampled mid-cycle
	task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata, output logic err);
		int waits;
		step();
		pwrite = write;
		paddr  = addr;
		pwdata = wdata;
		drive_phase(APB_SETUP);
		step();
		drive_phase(APB_ACCESS);
		waits = 0;
		#10;
		while (!pready && waits < 16) begin
			step();
			#10;
			waits++;
		end
		if (!pready) begin
			$display("APB transfer to address 0x%02h never got pready", addr);
			errors++;
			rdata = '0;
			err   = 1'b0;
		end else begin
			rdata = prdata;
			err   = pslverr;
			// the write lands at the edge that ends this access cycle
			if (write && int'(addr[APB_ADDR_W-1:2]) < NUM_PREG) begin
				shadow[addr[PREG_W+1:2]] = wdata;
			end
		end
		step();
		drive_phase(APB_IDLE);
	endtask

	// ==============================
	// stimulus
	// ==============================
	initial begin
		logic [DATA_W-1:0]     rd;
		logic                  err;
		logic [DATA_W-1:0]     val;
		logic [APB_ADDR_W-1:0] addr;
		int                    a;
		int                    b;
		int                    target;
		seed         = 32'h8226;
		errors       = 0;
		err_base     = 0;
		tests_run    = 0;
		tests_failed = 0;
		rst          = 1'b1;
		req_reg      = '0;
		req_valid    = '0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		acked_since  = '0;
		drive_phase(APB_IDLE);
		for (int i = 0; i < NUM_PREG; i++) begin
			shadow[i] = '0;
		end

		// outputs must stay quiet while reset is held for 10 cycles
		for (int c = 0; c < 10; c++) begin
			@(negedge clk);
			assert (req_ack == '0 && !pready && !pslverr) else
				report_fail("outputs not cleared during reset");
		end
		rst = 1'b0;
		close_test("reset state");

		// every register gets random data, with random byte lane bits too
		for (int i = 0; i < NUM_PREG; i++) begin
			draw_requests();
			val = $random(seed);
			apb_access(1'b1, APB_ADDR_W'((i << 2) | ($random(seed) & 3)), val, rd, err);
			assert (!err) else report_fail($sformatf("write to reg %0d flagged an error", i));
		end
		for (int i = 0; i < NUM_PREG; i++) begin
			apb_access(1'b0, APB_ADDR_W'(i << 2), '0, rd, err);
			assert (rd == shadow[i] && !err) else
				report_fail($sformatf("reg %0d read 0x%08h, expected 0x%08h", i, rd, shadow[i]));
		end
		close_test("apb write and read");

		// addresses past the file give pslverr, drop writes and read as zero
		for (int k = 0; k < 4; k++) begin
			addr = APB_ADDR_W'((NUM_PREG << 2) + ($random(seed) & 127));
			apb_access(1'b1, addr, $random(seed), rd, err);
			assert (err) else report_fail($sformatf("write to 0x%02h gave no pslverr", addr));
			apb_access(1'b0, addr, '0, rd, err);
			assert (err && rd == '0) else
				report_fail($sformatf("read of 0x%02h gave 0x%08h without pslverr", addr, rd));
		end
		for (int i = 0; i < NUM_PREG; i++) begin
			apb_access(1'b0, APB_ADDR_W'(i << 2), '0, rd, err);
			assert (rd == shadow[i]) else
				report_fail($sformatf("reg %0d changed to 0x%08h by a bad write", i, rd));
		end
		close_test("apb address error");

		// fixed requesters with their valid bits sometimes dropped
		for (int c = 0; c < 40; c++) begin
			draw_requests();
			if (c % 2 == 0) begin
				req_valid[FIXED_PORTS-1:0] = '0;
			end
			step();
		end
		close_test("fixed requesters");

		// random load on all requesters is checked by the per-cycle checks in step
		for (int c = 0; c < 100; c++) begin
			draw_requests();
			step();
		end
		close_test("dynamic port limits");

		// with all dynamic requesters asking, each must win within DYN_REQ cycles
		draw_requests();
		req_valid   = '1;
		acked_since = '0;
		for (int c = 0; c < DYN_REQ; c++) begin
			step();
		end
		assert (&acked_since[NUM_REQ-1:FIXED_PORTS]) else
			report_fail($sformatf("dynamic requesters starved, acks seen %b", acked_since));
		// two dynamic requesters fit the free ports and win every cycle
		a = FIXED_PORTS + int'($unsigned($random(seed)) % DYN_REQ);
		b = FIXED_PORTS + int'((a - FIXED_PORTS + 1 + $unsigned($random(seed)) % (DYN_REQ - 1))
			% DYN_REQ);
		req_valid    = '0;
		req_valid[a] = 1'b1;
		req_valid[b] = 1'b1;
		for (int c = 0; c < 2 * DYN_REQ; c++) begin
			step();
			assert (req_ack[a] && req_ack[b]) else
				report_fail($sformatf("requesters %0d and %0d not both acked", a, b));
		end
		close_test("fairness");

		// every requester reads the register being rewritten
		for (int k = 0; k < 6; k++) begin
			target = int'($unsigned($random(seed)) % NUM_PREG);
			for (int i = 0; i < NUM_REQ; i++) begin
				req_reg[i] = PREG_W'(target);
			end
			req_valid = '1;
			val = $random(seed);
			apb_access(1'b1, APB_ADDR_W'(target << 2), val, rd, err);
			step();
			assert (req_data[0] == val) else
				report_fail($sformatf("reg %0d still reads 0x%08h after write",
					target, req_data[0]));
		end
		close_test("write during requests");

		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
